/* logic/sv39_pkg.sv */
package sv39_pkg;

    localparam int num_walkers       = 4;
    localparam int va_width          = 39;
    localparam int pa_width          = 56;
    localparam int ppn_width         = 44;
    localparam int vpn_width         = 9;
    localparam int page_offset_width = 12;
    localparam int pte_width         = 64;

    // round-robin pointer into the walker array
    localparam int walker_idx_width  = (num_walkers > 1) ? $clog2(num_walkers) : 1;

    // Sv39 PTE, bit 0 is v
    typedef struct packed {
        logic [pte_width-ppn_width-11:0] reserved;
        logic [ppn_width-1:0]            ppn;
        logic [1:0]                      rsw;
        logic                            d;
        logic                            a;
        logic                            g;
        logic                            u;
        logic                            x;
        logic                            w;
        logic                            r;
        logic                            v;
    } pte_t;

    typedef struct packed {
        logic [va_width-1:0]  va;
        logic [ppn_width-1:0] root_ppn;
    } walk_req_t;

    typedef struct packed {
        logic [va_width-1:0] va;
        logic [pa_width-1:0] pa;
        logic                fault;
        logic [1:0]          fault_level;  // level where the walk stopped
    } walk_rsp_t;

    // byte address of one PTE
    typedef logic [pa_width-1:0] mem_read_t;

    typedef enum logic [1:0] {
        idle,
        read_pte,
        check,
        respond
    } walk_state_t;

endpackage

/* logic/walk_dispatch.sv */
`timescale 1ns/1ps

module walk_dispatch import sv39_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  walk_req_t              req_data,
    input  logic [num_walkers-1:0] walk_busy,
    output logic                   req_ack,
    output logic [num_walkers-1:0] walk_start,
    output walk_req_t              walk_req
);

    logic [num_walkers-1:0] idle_onehot;
    logic                   any_idle;

    // priority encoder, lowest idle walker wins
    always_comb begin : pick_walker
        logic found;
        found = 1'b0;
        idle_onehot = '0;
        for (int i = 0; i < num_walkers; i++) begin
            if (!walk_busy[i] && !found) begin
                idle_onehot[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign any_idle = |idle_onehot;

    // four-phase acceptance, one start pulse per accepted request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_ack    <= 1'b0;
            walk_start <= '0;
        end else begin
            walk_start <= '0;
            if (!req_ack) begin
                if (req_valid && any_idle) begin
                    req_ack    <= 1'b1;
                    walk_start <= idle_onehot;
                end
            end else if (!req_valid) begin
                req_ack <= 1'b0;  // phase 4
            end
        end
    end

    // shared payload, sampled by the started walker on the next edge
    always_ff @(posedge clk) begin
        if (!req_ack && req_valid && any_idle) begin
            walk_req <= req_data;
        end
    end

endmodule

/* logic/page_walker.sv */
`timescale 1ns/1ps

module page_walker import sv39_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  walk_req_t walk_req,
    input  logic      rd_ack,
    input  pte_t      rd_data,
    input  logic      res_ack,
    output logic      busy,
    output logic      rd_req,
    output mem_read_t rd_addr,
    output logic      res_req,
    output walk_rsp_t res_data
);

    walk_state_t          state;
    logic [1:0]           level;
    walk_req_t            req_q;
    logic [ppn_width-1:0] table_ppn;
    pte_t                 pte_q;
    logic [pa_width-1:0]  pa_q;
    logic                 fault_q;
    logic [vpn_width-1:0] vpn_sel;
    logic                 is_leaf;
    logic                 walk_done;
    logic                 walk_fault;

    // VPN slice for the current level
    always_comb begin
        case (level)
            2'd2:    vpn_sel = req_q.va[page_offset_width + 2*vpn_width +: vpn_width];
            2'd1:    vpn_sel = req_q.va[page_offset_width + vpn_width +: vpn_width];
            default: vpn_sel = req_q.va[page_offset_width +: vpn_width];
        endcase
    end

    assign is_leaf = pte_q.r | pte_q.x;

    // stop on invalid, on any leaf, or at the last level
    assign walk_done = !pte_q.v || is_leaf || (level == 2'd0);

    // a leaf is only legal at level 0, and level 0 must be a leaf
    assign walk_fault = !pte_q.v || (is_leaf != (level == 2'd0));

    assign busy   = (state != idle);
    assign rd_req = (state == read_pte);

    // table base plus 8 bytes per entry
    assign rd_addr = {table_ppn, vpn_sel, 3'b000};

    assign res_data = '{
        va:          req_q.va,
        pa:          pa_q,
        fault:       fault_q,
        fault_level: level
    };

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= idle;
            level   <= 2'd2;
            res_req <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= read_pte;
                        level <= 2'd2;
                    end
                end
                read_pte: begin
                    if (rd_ack) begin
                        state <= check;
                    end
                end
                check: begin
                    // wait for the read ack to drop before moving on
                    if (!rd_ack) begin
                        if (walk_done) begin
                            state   <= respond;
                            res_req <= 1'b1;
                        end else begin
                            level <= level - 2'd1;
                            state <= read_pte;
                        end
                    end
                end
                respond: begin
                    if (res_req && res_ack) begin
                        res_req <= 1'b0;
                    end else if (!res_req && !res_ack) begin
                        state <= idle;  // handshake complete
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            req_q     <= walk_req;
            table_ppn <= walk_req.root_ppn;
        end
        if (state == read_pte && rd_ack) begin
            pte_q <= rd_data;
        end
        if (state == check && !rd_ack) begin
            if (walk_done) begin
                fault_q <= walk_fault;
                if (walk_fault) begin
                    pa_q <= '0;
                end else begin
                    pa_q <= {pte_q.ppn, req_q.va[page_offset_width-1:0]};
                end
            end else begin
                table_ppn <= pte_q.ppn;  // next table
            end
        end
    end

endmodule

/* logic/req_arbiter.sv */
`timescale 1ns/1ps

module req_arbiter import sv39_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [num_walkers-1:0] in_req,
    input  payload_t               in_data [num_walkers],
    input  logic                   out_ack,
    output logic [num_walkers-1:0] in_ack,
    output logic                   out_req,
    output payload_t               out_data
);

    logic                        locked;
    logic                        seen_ack;
    logic [walker_idx_width-1:0] grant;
    logic [walker_idx_width-1:0] next_winner;
    logic                        any_req;
    logic                        release_now;

    // round robin, search starts after the last winner
    always_comb begin : rr_pick
        logic found;
        int   cand;
        found = 1'b0;
        next_winner = grant;
        for (int i = 1; i <= num_walkers; i++) begin
            cand = (int'(grant) + i) % num_walkers;
            if (in_req[cand] && !found) begin
                next_winner = walker_idx_width'(cand);
                found = 1'b1;
            end
        end
    end

    assign any_req = |in_req;

    // downstream exchange finished once ack has come and gone
    assign release_now = locked && seen_ack && !out_ack;

    assign out_req  = locked && !seen_ack && in_req[grant];
    assign out_data = in_data[grant];

    always_comb begin
        in_ack = '0;
        if (locked) begin
            in_ack[grant] = out_ack;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            locked   <= 1'b0;
            seen_ack <= 1'b0;
            grant    <= walker_idx_width'(num_walkers - 1);  // walker 0 goes first
        end else begin
            if (!locked || release_now) begin
                locked   <= any_req;
                seen_ack <= 1'b0;
                if (any_req) begin
                    grant <= next_winner;
                end
            end else if (out_ack) begin
                seen_ack <= 1'b1;
            end
        end
    end

endmodule

/* logic/mmu_walk_top.sv */
`timescale 1ns/1ps

module mmu_walk_top import sv39_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    output logic      req_ack,
    input  walk_req_t req_data,
    output logic      rsp_req,
    input  logic      rsp_ack,
    output walk_rsp_t rsp_data,
    output logic      mem_req,
    input  logic      mem_ack,
    output mem_read_t mem_addr,
    input  pte_t      mem_data
);

    logic [num_walkers-1:0] walk_start;
    logic [num_walkers-1:0] walk_busy;
    walk_req_t              walk_req;

    logic [num_walkers-1:0] rd_req;
    logic [num_walkers-1:0] rd_ack;
    mem_read_t              rd_addr [num_walkers];

    logic [num_walkers-1:0] res_req;
    logic [num_walkers-1:0] res_ack;
    walk_rsp_t              res_data [num_walkers];

    walk_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_data   (req_data),
        .walk_busy  (walk_busy),
        .req_ack    (req_ack),
        .walk_start (walk_start),
        .walk_req   (walk_req)
    );

    for (genvar i = 0; i < num_walkers; i++) begin : g_walker
        page_walker u_walker (
            .clk      (clk),
            .reset    (reset),
            .start    (walk_start[i]),
            .walk_req (walk_req),
            .rd_ack   (rd_ack[i]),
            .rd_data  (mem_data),  // broadcast, only the acked walker samples
            .res_ack  (res_ack[i]),
            .busy     (walk_busy[i]),
            .rd_req   (rd_req[i]),
            .rd_addr  (rd_addr[i]),
            .res_req  (res_req[i]),
            .res_data (res_data[i])
        );
    end

    req_arbiter #(.payload_t(mem_read_t)) u_mem_arb (
        .clk      (clk),
        .reset    (reset),
        .in_req   (rd_req),
        .in_data  (rd_addr),
        .out_ack  (mem_ack),
        .in_ack   (rd_ack),
        .out_req  (mem_req),
        .out_data (mem_addr)
    );

    req_arbiter #(.payload_t(walk_rsp_t)) u_rsp_arb (
        .clk      (clk),
        .reset    (reset),
        .in_req   (res_req),
        .in_data  (res_data),
        .out_ack  (rsp_ack),
        .in_ack   (res_ack),
        .out_req  (rsp_req),
        .out_data (rsp_data)
    );

endmodule

/* test/pte_memory_model.sv */
`timescale 1ns/1ps

module pte_memory_model import sv39_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic [2:0] delay,
    input  logic      mem_req,
    input  mem_read_t mem_addr,
    output logic      mem_ack,
    output pte_t      mem_data
);

    // sparse page table storage, absent entries read as zero
    pte_t mem [mem_read_t];

    int wait_cnt;

    initial begin
        mem_ack  = 1'b0;
        mem_data = '0;
        wait_cnt = 0;
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ack  <= 1'b0;
            mem_data <= '0;
            wait_cnt <= 0;
        end else if (mem_req && !mem_ack) begin
            if (wait_cnt >= int'(delay)) begin
                mem_ack  <= 1'b1;  // data valid with ack
                wait_cnt <= 0;
                if (mem.exists(mem_addr)) begin
                    mem_data <= mem[mem_addr];
                end else begin
                    mem_data <= '0;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;  // phase 4
        end
    end

endmodule

/* test/mmu_walk_props.sv */
`timescale 1ns/1ps

module mmu_walk_props import sv39_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      req_valid,
    input logic      req_ack,
    input walk_req_t req_data,
    input logic      rsp_req,
    input logic      rsp_ack,
    input walk_rsp_t rsp_data,
    input logic      mem_req,
    input logic      mem_ack,
    input mem_read_t mem_addr
);

    int fail_count = 0;  // failed checks so far

    // outputs quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> !req_ack && !rsp_req && !mem_req)
        else begin
            $error("outputs not low after reset");
            fail_count++;
        end

    // request port, ack follows valid in both directions
    a_req_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(req_ack) |-> req_valid)
        else begin
            $error("req_ack rose without req_valid");
            fail_count++;
        end
    a_req_ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(req_ack) |-> !req_valid)
        else begin
            $error("req_ack fell while req_valid high");
            fail_count++;
        end
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        req_valid && $past(req_valid) |-> req_data == $past(req_data))
        else begin
            $error("req_data changed while req_valid high");
            fail_count++;
        end

    // response port
    a_rsp_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(rsp_req) |-> !rsp_ack)
        else begin
            $error("rsp_req rose before rsp_ack fell");
            fail_count++;
        end
    a_rsp_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(rsp_req) |-> rsp_ack)
        else begin
            $error("rsp_req fell without rsp_ack");
            fail_count++;
        end
    a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        rsp_req && $past(rsp_req) |-> rsp_data == $past(rsp_data))
        else begin
            $error("rsp_data changed while rsp_req high");
            fail_count++;
        end

    // memory port, one read in flight at a time
    a_mem_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else begin
            $error("mem_req rose before mem_ack fell");
            fail_count++;
        end
    a_mem_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(mem_req) |-> mem_ack)
        else begin
            $error("mem_req fell without mem_ack");
            fail_count++;
        end
    a_mem_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req && $past(mem_req) |-> mem_addr == $past(mem_addr))
        else begin
            $error("mem_addr changed while mem_req high");
            fail_count++;
        end

endmodule

bind mmu_walk_top mmu_walk_props u_props (.*);

/* test/tb_mmu_walk.sv */
`timescale 1ns/1ps

module tb_mmu_walk import sv39_pkg::*; ();

    localparam logic [ppn_width-1:0] root_ppn = 44'h100;
    localparam logic [ppn_width-1:0] l1_ppn   = 44'h101;
    localparam logic [ppn_width-1:0] l0_ppn   = 44'h102;
    localparam logic [ppn_width-1:0] leaf_off = 44'h4000;
    localparam int num_random    = 36;
    localparam int max_delay     = 5;
    localparam int cycles_per_rq = 3 * (max_delay + 4) + 2 * max_delay + 10;
    localparam int cycle_limit   = (num_random + num_walkers + 1) * cycles_per_rq + 300;

    logic clk = 1'b0;
    logic reset;
    logic req_valid;
    logic req_ack;
    walk_req_t req_data;
    logic rsp_req;
    logic rsp_ack = 1'b0;
    walk_rsp_t rsp_data;
    logic mem_req;
    logic mem_ack;
    mem_read_t mem_addr;
    pte_t mem_data;
    logic [2:0] mem_delay;

    pte_t pt [mem_read_t];          // testbench copy of the page table
    bit   sb [logic [va_width-1:0]]; // outstanding VAs
    logic [31:0] rng;
    logic [31:0] rsp_rng;           // separate stream for the ack delays
    string test_name;
    logic rsp_hold;
    int rsp_wait;
    int rsp_delay;
    int in_flight;
    int cycles;
    logic req_ack_d;
    logic [va_width-1:0] done_va;

    always #20 clk = ~clk;

    mmu_walk_top uut (.*);

    pte_memory_model u_mem (
        .clk(clk), .reset(reset), .delay(mem_delay), .mem_req(mem_req),
        .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_data(mem_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int next_rand();
        rng = xorshift(rng);
        return int'(rng[30:0]);
    endfunction

    task automatic put_pte(input logic [ppn_width-1:0] tbl, input int idx, input pte_t pte);
        mem_read_t a;
        a = {tbl, 9'(idx), 3'b000};
        pt[a] = pte;
        u_mem.mem[a] = pte;
    endtask

    function automatic pte_t make_pte(input logic [ppn_width-1:0] ppn, input logic v,
                                      input logic r, input logic x);
        pte_t p;
        p = '0;
        p.ppn = ppn;
        p.v = v;
        p.r = r;
        p.x = x;
        return p;
    endfunction

    task automatic build_table();
        put_pte(root_ppn, 0, make_pte(l1_ppn, 1, 0, 0));
        put_pte(root_ppn, 2, make_pte(44'h7000, 1, 1, 0));  // leaf at level 2
        put_pte(l1_ppn, 0, make_pte(l0_ppn, 1, 0, 0));
        put_pte(l1_ppn, 1, make_pte(44'h7100, 1, 1, 1));    // leaf at level 1
        for (int n = 0; n < 8; n++) begin
            if (n == 5) begin
                put_pte(l0_ppn, n, make_pte(leaf_off + n, 0, 1, 0));
            end else if (n == 6) begin
                put_pte(l0_ppn, n, make_pte(leaf_off + n, 1, 0, 0));  // not a leaf
            end else begin
                put_pte(l0_ppn, n, make_pte(leaf_off + n, 1, 1, n[0]));
            end
        end
    endtask

    // reference walk over the testbench table
    function automatic walk_rsp_t expect_rsp(input logic [va_width-1:0] va);
        walk_rsp_t r;
        logic [ppn_width-1:0] ppn;
        mem_read_t a;
        pte_t p;
        r = '0;
        r.va = va;
        ppn = root_ppn;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            a = {ppn, va[12 + 9*lvl +: 9], 3'b000};
            p = pt.exists(a) ? pt[a] : pte_t'('0);
            r.fault_level = 2'(lvl);
            if (!p.v || ((p.r || p.x) && lvl != 0) || (!(p.r || p.x) && lvl == 0)) begin
                r.fault = 1'b1;
                return r;
            end
            if (lvl == 0) begin
                r.pa = {p.ppn, va[11:0]};
                return r;
            end
            ppn = p.ppn;
        end
        return r;
    endfunction

    // address read at some level of an outstanding walk
    function automatic bit addr_expected(input mem_read_t addr);
        logic [ppn_width-1:0] ppn;
        mem_read_t a;
        pte_t p;
        foreach (sb[va]) begin
            ppn = root_ppn;
            for (int lvl = 2; lvl >= 0; lvl--) begin
                a = {ppn, va[12 + 9*lvl +: 9], 3'b000};
                if (a == addr) begin
                    return 1'b1;
                end
                p = pt.exists(a) ? pt[a] : pte_t'('0);
                ppn = p.ppn;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [va_width-1:0] pick_va(input int n);
        logic [va_width-1:0] va;
        int sel;
        do begin
            sel = (n < 12) ? n : next_rand() % 12;  // first twelve visit every slot kind
            va = '0;
            va[11:0] = 12'(next_rand());
            if (sel < 8) begin
                va[20:12] = 9'(sel);  // level-0 slot, 5 invalid and 6 non-leaf
            end else if (sel == 8) begin
                va[38:30] = 9'd1;     // level-2 invalid
            end else if (sel == 9) begin
                va[38:30] = 9'd2;
            end else begin
                va[29:21] = 9'(sel - 9);  // level-1 leaf or invalid
            end
        end while (sb.exists(va));
        return va;
    endfunction

    task automatic start_req(input logic [va_width-1:0] va);
        sb[va] = 1'b1;
        @(posedge clk);
        req_data  <= '{va: va, root_ppn: root_ppn};
        req_valid <= 1'b1;
        mem_delay <= 3'(next_rand() % (max_delay + 1));
    endtask

    task automatic finish_req();
        while (!req_ack) @(posedge clk);
        req_valid <= 1'b0;
        @(posedge clk);
        while (req_ack) @(posedge clk);
    endtask

    task automatic wait_drained();
        while (sb.size() != 0) @(posedge clk);
    endtask

    // response side, random ack delay and counting of open walks
    always @(posedge clk) begin
        req_ack_d <= req_ack;
        if (reset) begin
            rsp_ack   <= 1'b0;
            rsp_wait  <= 0;
            in_flight <= 0;
        end else begin
            if (rsp_req && !rsp_ack && !rsp_hold) begin
                if (rsp_wait >= rsp_delay) begin
                    rsp_ack   <= 1'b1;
                    done_va   <= rsp_data.va;
                    rsp_wait  <= 0;
                    rsp_rng    = xorshift(rsp_rng);
                    rsp_delay <= int'(rsp_rng[30:0]) % (max_delay + 1);
                end else begin
                    rsp_wait <= rsp_wait + 1;
                end
            end
            if (!rsp_req && rsp_ack) begin
                rsp_ack <= 1'b0;
                sb.delete(done_va);
            end
            in_flight <= in_flight + int'(req_ack && !req_ack_d) - int'(!rsp_req && rsp_ack);
        end
    end

    a_rsp_value: assert property (@(posedge clk) disable iff (reset)
        rsp_req && !rsp_ack |-> rsp_data == expect_rsp(rsp_data.va))
        else begin
            $display("Mismatch %s: expected %h actual %h", test_name,
                     expect_rsp(rsp_data.va), rsp_data);
            $display("STATUS: FAIL");
            $fatal(1);
        end

    a_rsp_known: assert property (@(posedge clk) disable iff (reset)
        rsp_req && !rsp_ack |-> sb.exists(rsp_data.va))
        else begin
            $display("%s: response for a VA that is not outstanding, %h", test_name, rsp_data.va);
            $display("STATUS: FAIL");
            $fatal(1);
        end

    a_mem_addr: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> addr_expected(mem_addr))
        else begin
            $display("%s: memory read at %h belongs to no outstanding walk", test_name, mem_addr);
            $display("STATUS: FAIL");
            $fatal(1);
        end

    // an accept needs a free walker
    a_accept_limit: assert property (@(posedge clk) disable iff (reset)
        req_ack && !req_ack_d |-> in_flight < num_walkers)
        else begin
            $display("%s: request accepted with all %0d walkers busy", test_name, num_walkers);
            $display("STATUS: FAIL");
            $fatal(1);
        end

    // bound handshake checks on the top-level ports
    always @(posedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            $display("%s: handshake protocol check failed on a top-level port", test_name);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    initial begin
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_data    = '0;
        mem_delay   = '0;
        rsp_hold    = 1'b0;
        rsp_delay   = 0;
        cycles      = 0;
        rng         = 32'heb40_94aa;
        rsp_rng     = 32'heb40_94aa;
        test_name   = "random_mix";
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < num_random; i++) begin
            start_req(pick_va(i));
            finish_req();
        end
        wait_drained();

        test_name = "backpressure";
        rsp_hold <= 1'b1;
        for (int i = 0; i < num_walkers; i++) begin
            start_req(pick_va(num_random + i));
            finish_req();
        end
        start_req(pick_va(num_random + num_walkers));  // no walker free for this one
        repeat (20) @(posedge clk);
        rsp_hold <= 1'b0;
        finish_req();
        wait_drained();
        repeat (5) @(posedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* verilog.f */
logic/sv39_pkg.sv
logic/walk_dispatch.sv
logic/page_walker.sv
logic/req_arbiter.sv
logic/mmu_walk_top.sv
test/pte_memory_model.sv
test/mmu_walk_props.sv
test/tb_mmu_walk.sv
